// File: verilog/sh_mem_pkg.sv
package sh_mem_pkg;

	// ********************
	// Sizes and widths
	// ********************
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Command queue slots, also the sender's starting credit count
	localparam int queue_depth = 4;
	localparam int ptr_w = 2;

	// Response credits held by the unit
	localparam int rsp_credit_max = 7;
	localparam int rsp_cnt_w = $clog2(rsp_credit_max + 1);

	// Bit 7 of the byte written back by test-and-set
	localparam logic [7:0] tas_set_mask = 8'h80;

	// ********************
	// Encodings
	// ********************
	typedef enum logic [1:0] {
		op_load  = 2'd0,
		op_store = 2'd1,
		op_tas   = 2'd2
	} mem_op_e;

	typedef enum logic [1:0] {
		sz_byte = 2'd0,
		sz_word = 2'd1,
		sz_long = 2'd2
	} mem_size_e;

	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_read      = 3'd1,
		st_write     = 3'd2,
		st_tas_read  = 3'd3,
		st_tas_write = 3'd4
	} fsm_state_e;

endpackage

// File: verilog/mem_cmd_if.sv
interface mem_cmd_if;

	// Head entry of the command queue
	logic                           valid;
	sh_mem_pkg::mem_op_e            op;
	sh_mem_pkg::mem_size_e          size;
	logic [sh_mem_pkg::addr_w-1:0]  addr;
	logic [sh_mem_pkg::data_w-1:0]  wdata;

	// Sequencer takes the head entry
	logic                           pop;

	modport cmd_queue (
		output valid,
		output op,
		output size,
		output addr,
		output wdata,
		input  pop
	);

	modport access_fsm (
		input  valid,
		input  op,
		input  size,
		input  addr,
		input  wdata,
		output pop
	);

endinterface

// File: verilog/cmd_queue.sv
module cmd_queue (
	input  logic                          CLK,
	input  logic                          RST_N,
	input  logic                          push,
	input  sh_mem_pkg::mem_op_e           op,
	input  sh_mem_pkg::mem_size_e         size,
	input  logic [sh_mem_pkg::addr_w-1:0] addr,
	input  logic [sh_mem_pkg::data_w-1:0] wdata,
	output logic                          credit_ret,
	mem_cmd_if.cmd_queue                  head
);

	sh_mem_pkg::mem_op_e           op_mem    [sh_mem_pkg::queue_depth];
	sh_mem_pkg::mem_size_e         size_mem  [sh_mem_pkg::queue_depth];
	logic [sh_mem_pkg::addr_w-1:0] addr_mem  [sh_mem_pkg::queue_depth];
	logic [sh_mem_pkg::data_w-1:0] wdata_mem [sh_mem_pkg::queue_depth];

	logic [sh_mem_pkg::ptr_w-1:0]  wr_ptr;
	logic [sh_mem_pkg::ptr_w-1:0]  rd_ptr;
	logic [sh_mem_pkg::ptr_w:0]    count;
	logic                          do_pop;

	assign do_pop = head.pop & head.valid;

	// Entry storage
	always_ff @(posedge CLK) begin
		if (push) begin
			op_mem[wr_ptr]    <= op;
			size_mem[wr_ptr]  <= size;
			addr_mem[wr_ptr]  <= addr;
			wdata_mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_ret <= 1'b0;
		end
		else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase

			// One credit back to the sender per released slot
			credit_ret <= do_pop;
		end
	end

	// ********************
	// Head entry
	// ********************
	assign head.valid = (count != '0);
	assign head.op    = op_mem[rd_ptr];
	assign head.size  = size_mem[rd_ptr];
	assign head.addr  = addr_mem[rd_ptr];
	assign head.wdata = wdata_mem[rd_ptr];

endmodule

// File: verilog/rsp_credit_counter.sv
module rsp_credit_counter (
	input  logic CLK,
	input  logic RST_N,
	input  logic grant,
	input  logic spend,
	output logic has_credit
);

	logic [sh_mem_pkg::rsp_cnt_w-1:0] count;
	logic                             at_max;

	assign at_max = (count == sh_mem_pkg::rsp_credit_max[sh_mem_pkg::rsp_cnt_w-1:0]);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			count <= '0;
		end
		else begin
			// Grant and spend together cancel out
			if (grant && !spend && !at_max) begin
				count <= count + 1'b1;
			end
			else if (spend && !grant && has_credit) begin
				count <= count - 1'b1;
			end
		end
	end

	assign has_credit = (count != '0);

endmodule

// File: verilog/access_fsm.sv
module access_fsm (
	input  logic                          CLK,
	input  logic                          RST_N,
	mem_cmd_if.access_fsm                 cmd,
	input  logic                          has_credit,
	output logic                          spend,
	input  logic                          bus_wait,
	input  logic [3:0]                    lanes,
	input  logic [sh_mem_pkg::data_w-1:0] rdata,
	input  logic                          byte_zero,
	output sh_mem_pkg::mem_size_e         size,
	output logic [sh_mem_pkg::addr_w-1:0] addr,
	output logic [sh_mem_pkg::data_w-1:0] wdata,
	output logic                          bus_req,
	output logic                          bus_wr,
	output logic                          bus_tas,
	output logic [3:0]                    bus_ba,
	output logic                          rsp_valid,
	output logic                          rsp_t,
	output logic [sh_mem_pkg::data_w-1:0] rsp_data
);

	sh_mem_pkg::fsm_state_e state;
	sh_mem_pkg::fsm_state_e state_nxt;
	logic                   start;
	logic                   xfer_done;

	// Stores need no response slot
	assign start = (state == sh_mem_pkg::st_idle) && cmd.valid &&
	               ((cmd.op == sh_mem_pkg::op_store) || has_credit);
	assign cmd.pop = start;
	assign spend   = start && (cmd.op != sh_mem_pkg::op_store);

	assign xfer_done = bus_req && !bus_wait;

	// ********************
	// Sequencer
	// ********************
	always_comb begin
		state_nxt = state;
		case (state)
			sh_mem_pkg::st_idle: begin
				if (start) begin
					case (cmd.op)
						sh_mem_pkg::op_load:  state_nxt = sh_mem_pkg::st_read;
						sh_mem_pkg::op_store: state_nxt = sh_mem_pkg::st_write;
						default:              state_nxt = sh_mem_pkg::st_tas_read;
					endcase
				end
			end
			sh_mem_pkg::st_tas_read: begin
				if (!bus_wait) state_nxt = sh_mem_pkg::st_tas_write;
			end
			sh_mem_pkg::st_read, sh_mem_pkg::st_write, sh_mem_pkg::st_tas_write: begin
				if (!bus_wait) state_nxt = sh_mem_pkg::st_idle;
			end
			default: state_nxt = sh_mem_pkg::st_idle;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= sh_mem_pkg::st_idle;
			rsp_valid <= 1'b0;
		end
		else begin
			state     <= state_nxt;
			rsp_valid <= !bus_wait && ((state == sh_mem_pkg::st_read) ||
			                           (state == sh_mem_pkg::st_tas_write));
		end
	end

	// Command latch, TAS write-back and response data
	always_ff @(posedge CLK) begin
		if (start) begin
			addr  <= cmd.addr;
			wdata <= cmd.wdata;
			size  <= (cmd.op == sh_mem_pkg::op_tas) ? sh_mem_pkg::sz_byte : cmd.size;
		end
		else if (xfer_done && state == sh_mem_pkg::st_tas_read) begin
			wdata <= {{(sh_mem_pkg::data_w - 8){1'b0}}, rdata[7:0] | sh_mem_pkg::tas_set_mask};
		end

		if (xfer_done && state == sh_mem_pkg::st_read) begin
			rsp_data <= rdata;
			rsp_t    <= 1'b0;
		end
		else if (xfer_done && state == sh_mem_pkg::st_tas_read) begin
			rsp_data <= {{(sh_mem_pkg::data_w - 8){1'b0}}, rdata[7:0]};
			rsp_t    <= byte_zero;
		end
	end

	// ********************
	// Bus outputs
	// ********************
	assign bus_req = (state != sh_mem_pkg::st_idle);
	assign bus_wr  = (state == sh_mem_pkg::st_write) || (state == sh_mem_pkg::st_tas_write);
	// Lock held over both TAS accesses
	assign bus_tas = (state == sh_mem_pkg::st_tas_read) || (state == sh_mem_pkg::st_tas_write);
	assign bus_ba  = bus_req ? lanes : 4'b0000;

endmodule

// File: verilog/lane_steer.sv
module lane_steer (
	input  sh_mem_pkg::mem_size_e         size,
	input  logic [1:0]                    addr_lo,
	input  logic [sh_mem_pkg::data_w-1:0] wdata,
	input  logic [sh_mem_pkg::data_w-1:0] bus_di,
	output logic [sh_mem_pkg::data_w-1:0] bus_do,
	output logic [3:0]                    lanes,
	output logic [sh_mem_pkg::data_w-1:0] rdata,
	output logic                          byte_zero
);

	logic [1:0]                    shift;
	logic [sh_mem_pkg::data_w-1:0] shifted;

	// ********************
	// Store side
	// ********************
	always_comb begin
		case (size)
			sh_mem_pkg::sz_byte: begin
				bus_do = {4{wdata[7:0]}};
				// Lane 3 carries address 0
				lanes  = 4'b0001 << ~addr_lo;
			end
			sh_mem_pkg::sz_word: begin
				bus_do = {2{wdata[15:0]}};
				lanes  = addr_lo[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				bus_do = wdata;
				lanes  = 4'b1111;
			end
		endcase
	end

	// ********************
	// Load side
	// ********************
	always_comb begin
		case (size)
			sh_mem_pkg::sz_byte: shift = ~addr_lo;
			sh_mem_pkg::sz_word: shift = {~addr_lo[1], 1'b0};
			default:             shift = 2'b00;
		endcase
	end

	// Addressed lane moved down to bits 7:0 or 15:0
	assign shifted = bus_di >> {shift, 3'b000};

	always_comb begin
		case (size)
			sh_mem_pkg::sz_byte: rdata = {{24{shifted[7]}}, shifted[7:0]};
			sh_mem_pkg::sz_word: rdata = {{16{shifted[15]}}, shifted[15:0]};
			default:             rdata = shifted;
		endcase
	end

	// Test-and-set result bit
	assign byte_zero = (shifted[7:0] == 8'h00);

endmodule

// File: verilog/sh_mem_unit.sv
module sh_mem_unit (
	input  logic                          CLK,
	input  logic                          RST_N,

	input  logic                          cmd_valid,
	input  sh_mem_pkg::mem_op_e           cmd_op,
	input  sh_mem_pkg::mem_size_e         cmd_size,
	input  logic [sh_mem_pkg::addr_w-1:0] cmd_addr,
	input  logic [sh_mem_pkg::data_w-1:0] cmd_wdata,
	output logic                          credit_ret,

	input  logic                          rsp_credit,
	output logic                          rsp_valid,
	output logic                          rsp_t,
	output logic [sh_mem_pkg::data_w-1:0] rsp_data,

	output logic [sh_mem_pkg::addr_w-1:0] bus_a,
	output logic [sh_mem_pkg::data_w-1:0] bus_do,
	output logic [3:0]                    bus_ba,
	output logic                          bus_wr,
	output logic                          bus_req,
	output logic                          bus_tas,
	input  logic [sh_mem_pkg::data_w-1:0] bus_di,
	input  logic                          bus_wait
);

	logic                          has_credit;
	logic                          spend;
	logic [3:0]                    lanes;
	logic [sh_mem_pkg::data_w-1:0] rdata;
	logic                          byte_zero;
	sh_mem_pkg::mem_size_e         size;
	logic [sh_mem_pkg::data_w-1:0] wdata;

	mem_cmd_if cmd_if ();

	cmd_queue cmd_queue_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.push       (cmd_valid),
		.op         (cmd_op),
		.size       (cmd_size),
		.addr       (cmd_addr),
		.wdata      (cmd_wdata),
		.credit_ret (credit_ret),
		.head       (cmd_if.cmd_queue)
	);

	rsp_credit_counter rsp_credit_counter_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.grant      (rsp_credit),
		.spend      (spend),
		.has_credit (has_credit)
	);

	access_fsm access_fsm_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cmd        (cmd_if.access_fsm),
		.has_credit (has_credit),
		.spend      (spend),
		.bus_wait   (bus_wait),
		.lanes      (lanes),
		.rdata      (rdata),
		.byte_zero  (byte_zero),
		.size       (size),
		.addr       (bus_a),
		.wdata      (wdata),
		.bus_req    (bus_req),
		.bus_wr     (bus_wr),
		.bus_tas    (bus_tas),
		.bus_ba     (bus_ba),
		.rsp_valid  (rsp_valid),
		.rsp_t      (rsp_t),
		.rsp_data   (rsp_data)
	);

	lane_steer lane_steer_i (
		.size      (size),
		.addr_lo   (bus_a[1:0]),
		.wdata     (wdata),
		.bus_di    (bus_di),
		.bus_do    (bus_do),
		.lanes     (lanes),
		.rdata     (rdata),
		.byte_zero (byte_zero)
	);

endmodule

// File: bench/tb_clock.sv
module tb_clock (
	output logic CLK,
	output logic RST_N
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (8) @(posedge CLK);
		RST_N <= 1'b1;
	end

endmodule

// File: bench/bus_model.sv
module bus_model (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [31:0] init_img [16],
	input  logic [31:0] bus_a,
	input  logic [31:0] bus_do,
	input  logic [3:0]  bus_ba,
	input  logic        bus_wr,
	input  logic        bus_req,
	output logic [31:0] bus_di,
	output logic        bus_wait,
	output int          writes
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] mem [16];
	logic [31:0] lfsr;
	logic        wait_bit;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	assign bus_di = mem[bus_a[5:2]];

	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < 16; i++) begin
				mem[i] <= init_img[i];
			end
			bus_wait <= 1'b0;
			writes   <= 0;
			lfsr     = 32'h9a57;
		end
		else begin
			if (bus_req && !bus_wait && bus_wr) begin
				// Lane i holds bits 8i+7 to 8i
				for (int i = 0; i < 4; i++) begin
					if (bus_ba[i]) begin
						mem[bus_a[5:2]][8*i +: 8] <= bus_do[8*i +: 8];
					end
				end
				writes <= writes + 1;
			end
			// Wait state on about one edge in four
			lfsr = lfsr_next(lfsr);
			wait_bit = lfsr[0];
			lfsr = lfsr_next(lfsr);
			bus_wait <= wait_bit & lfsr[0];
		end
	end

endmodule

// File: bench/sh_mem_unit_tb.sv
module sh_mem_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_words = 128;
	localparam int max_acc = 64;

	logic                  CLK;
	logic                  RST_N;
	logic                  cmd_valid;
	sh_mem_pkg::mem_op_e   cmd_op;
	sh_mem_pkg::mem_size_e cmd_size;
	logic [31:0]           cmd_addr;
	logic [31:0]           cmd_wdata;
	logic                  credit_ret;
	logic                  rsp_credit;
	logic                  rsp_valid;
	logic                  rsp_t;
	logic [31:0]           rsp_data;
	logic [31:0]           bus_a;
	logic [31:0]           bus_do;
	logic [31:0]           bus_di;
	logic [3:0]            bus_ba;
	logic                  bus_wr;
	logic                  bus_req;
	logic                  bus_tas;
	logic                  bus_wait;
	int                    writes;

	logic [31:0] vec [max_words];
	logic [31:0] img [16];
	logic [31:0] exp_img [16];

	// Expected bus accesses in issue order
	logic        acc_wr [max_acc];
	logic        acc_tas [max_acc];
	logic        acc_last [max_acc];
	logic [3:0]  acc_lanes [max_acc];
	logic [31:0] acc_data [max_acc];
	int          acc_rec [max_acc];
	int          rsp_rec [max_acc];

	int          nmem, nrec, nacc, nrsp, base;
	int          errors, sent, returned, credits, granted, responses, accesses, cycles;
	logic [31:0] lfsr;

	tb_clock tb_clock_i (.CLK(CLK), .RST_N(RST_N));

	bus_model bus_model_i (
		.CLK(CLK), .RST_N(RST_N), .init_img(img), .bus_a(bus_a), .bus_do(bus_do),
		.bus_ba(bus_ba), .bus_wr(bus_wr), .bus_req(bus_req), .bus_di(bus_di),
		.bus_wait(bus_wait), .writes(writes)
	);

	sh_mem_unit sh_mem_unit_i (
		.CLK(CLK), .RST_N(RST_N), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cmd_size(cmd_size), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
		.credit_ret(credit_ret), .rsp_credit(rsp_credit), .rsp_valid(rsp_valid),
		.rsp_t(rsp_t), .rsp_data(rsp_data), .bus_a(bus_a), .bus_do(bus_do),
		.bus_ba(bus_ba), .bus_wr(bus_wr), .bus_req(bus_req), .bus_tas(bus_tas),
		.bus_di(bus_di), .bus_wait(bus_wait)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] field(input int r, input int f);
		return vec[base + 6*r + f];
	endfunction

	// Big-endian lanes, address 0 on lane 3
	function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [31:0] a);
		if (size == 2'd0) return 4'b1000 >> a[1:0];
		if (size == 2'd1) return a[1] ? 4'b0011 : 4'b1100;
		return 4'b1111;
	endfunction

	function automatic logic [31:0] replicate(input logic [1:0] size, input logic [31:0] d);
		if (size == 2'd0) return {4{d[7:0]}};
		if (size == 2'd1) return {2{d[15:0]}};
		return d;
	endfunction

	task automatic check_data(input string name, input logic [sh_mem_pkg::data_w-1:0] exp,
	                          input logic [sh_mem_pkg::data_w-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_lanes(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic add_access(input logic wr, input logic tas, input logic [3:0] lanes,
	                          input logic [31:0] data, input int r, input logic last);
		logic [31:0] a;
		a = field(r, 2);
		acc_wr[nacc]    = wr;
		acc_tas[nacc]   = tas;
		acc_lanes[nacc] = lanes;
		acc_data[nacc]  = data;
		acc_rec[nacc]   = r;
		acc_last[nacc]  = last;
		nacc++;
		for (int i = 0; i < 4; i++) begin
			if (wr && lanes[i]) exp_img[a[5:2]][8*i +: 8] = data[8*i +: 8];
		end
	endtask

	task automatic check_reset_outputs();
		check_flag("bus_req", 1'b0, bus_req);
		check_flag("bus_wr", 1'b0, bus_wr);
		check_flag("bus_tas", 1'b0, bus_tas);
		check_lanes("bus_ba", 4'b0000, bus_ba);
		check_flag("credit_ret", 1'b0, credit_ret);
		check_flag("rsp_valid", 1'b0, rsp_valid);
	endtask

	initial begin
		logic [1:0]  sz;
		logic [7:0]  tas_byte;
		cmd_valid  = 1'b0;
		cmd_op     = sh_mem_pkg::op_load;
		cmd_size   = sh_mem_pkg::sz_byte;
		cmd_addr   = '0;
		cmd_wdata  = '0;
		rsp_credit = 1'b0;
		errors = 0;
		nacc = 0;
		nrsp = 0;
		$readmemh("bench/mem_vectors.txt", vec);
		nmem = int'(vec[0]);
		nrec = int'(vec[1]);
		base = 2 + nmem;
		for (int i = 0; i < 16; i++) begin
			img[i] = (i < nmem) ? vec[2 + i] : {4{i[3:0], 4'h5}} ^ 32'h0f1e2d3c;
			exp_img[i] = img[i];
		end
		for (int r = 0; r < nrec; r++) begin
			sz = field(r, 1) == 32'd0 ? 2'd0 : (field(r, 1) == 32'd1 ? 2'd1 : 2'd2);
			tas_byte = 8'(field(r, 4));
			if (field(r, 0) == 32'd1) begin
				add_access(1'b1, 1'b0, lane_mask(sz, field(r, 2)), replicate(sz, field(r, 3)),
				           r, 1'b1);
			end
			else if (field(r, 0) == 32'd2) begin
				add_access(1'b0, 1'b1, lane_mask(2'd0, field(r, 2)), '0, r, 1'b0);
				add_access(1'b1, 1'b1, lane_mask(2'd0, field(r, 2)),
				           {4{tas_byte | 8'h80}}, r, 1'b1);
				rsp_rec[nrsp] = r;
				nrsp++;
			end
			else begin
				add_access(1'b0, 1'b0, lane_mask(sz, field(r, 2)), '0, r, 1'b1);
				rsp_rec[nrsp] = r;
				nrsp++;
			end
		end

		// Outputs quiet in reset and one cycle after
		@(negedge CLK);
		while (!RST_N) begin
			check_reset_outputs();
			@(negedge CLK);
		end
		check_reset_outputs();
		$display("Test reset: outputs checked, errors %0d", errors);

		wait (accesses == nacc && responses == nrsp && returned == nrec);
		@(posedge CLK);
		for (int i = 0; i < 16; i++) begin
			check_data($sformatf("mem[%0d]", i), exp_img[i], bus_model_i.mem[i]);
		end
		// One write per store and per test-and-set
		if (writes != nacc - nrsp) begin
			$display("Bus model logged %0d writes where %0d were expected", writes, nacc - nrsp);
			errors++;
		end
		$display("Test memory image: checked, errors %0d", errors);
		$display("Commands %0d, accesses %0d, responses %0d, errors %0d",
		         nrec, accesses, responses, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// ********************
	// Sender and credits
	// ********************
	always @(posedge CLK) begin
		if (!RST_N) begin
			credits  = sh_mem_pkg::queue_depth;
			sent     = 0;
			returned = 0;
		end
		else begin
			if (credit_ret) begin
				credits++;
				returned++;
				if (returned > sent) begin
					$display("Credit returned for a command that was never sent");
					errors++;
				end
			end
			if (sent < nrec && credits > 0) begin
				cmd_valid <= 1'b1;
				cmd_op    <= sh_mem_pkg::mem_op_e'(field(sent, 0) & 32'h3);
				cmd_size  <= sh_mem_pkg::mem_size_e'(field(sent, 1) & 32'h3);
				cmd_addr  <= field(sent, 2);
				cmd_wdata <= field(sent, 3);
				credits--;
				sent++;
			end
			else begin
				cmd_valid <= 1'b0;
			end
		end
	end

	// ********************
	// Monitors
	// ********************
	always @(posedge CLK) begin
		if (!RST_N) begin
			granted = 0;
			lfsr    = 32'h9a57;
		end
		else begin
			if (bus_req && !bus_wait) begin
				if (accesses >= nacc) begin
					$display("Bus transfer at %0t with no access left to expect", $time);
					errors++;
				end
				else begin
					check_data("bus_a", field(acc_rec[accesses], 2), bus_a);
					check_flag("bus_wr", acc_wr[accesses], bus_wr);
					check_flag("bus_tas", acc_tas[accesses], bus_tas);
					check_lanes("bus_ba", acc_lanes[accesses], bus_ba);
					if (acc_wr[accesses]) check_data("bus_do", acc_data[accesses], bus_do);
					if (acc_last[accesses]) begin
						$display("Test command %0d: bus access done, errors %0d",
						         acc_rec[accesses], errors);
					end
				end
				accesses++;
			end
			if (rsp_valid) begin
				responses++;
				if (responses > granted || responses > nrsp) begin
					$display("Response at %0t beyond the credits granted or expected", $time);
					errors++;
				end
				else begin
					check_data("rsp_data", field(rsp_rec[responses-1], 4), rsp_data);
					check_flag("rsp_t", field(rsp_rec[responses-1], 5) != 0, rsp_t);
					$display("Test command %0d: response checked, errors %0d",
					         rsp_rec[responses-1], errors);
				end
			end
			lfsr = lfsr_next(lfsr);
			// Grants come in bursts, at most three ahead
			if (lfsr[0] && granted - responses < 3 && granted < nrsp) begin
				rsp_credit <= 1'b1;
				granted++;
			end
			else begin
				rsp_credit <= 1'b0;
			end
		end
	end

	initial cycles = 0;

	always @(posedge CLK) begin
		cycles++;
		if (cycles > 64 * nrec + 200) begin
			$display("Timeout: the run did not complete within %0d cycles", cycles - 1);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// File: sh_mem_unit.f
verilog/sh_mem_pkg.sv
verilog/mem_cmd_if.sv
verilog/cmd_queue.sv
verilog/rsp_credit_counter.sv
verilog/access_fsm.sv
verilog/lane_steer.sv
verilog/sh_mem_unit.sv
bench/tb_clock.sv
bench/bus_model.sv
bench/sh_mem_unit_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = sh_mem_unit_tb
FILELIST = sh_mem_unit.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/mem_vectors.txt
// Header: memory word count, record count; then memory words from address 0
// Records: op (0 load 1 store 2 tas) size (0 byte 1 word 2 long) addr wdata exp_rsp_data exp_rsp_t
00000004 0000000e
12345678 80ff007f 00000000 a5c3e10f
0 0 00000000 00000000 00000012 0
0 0 00000004 00000000 ffffff80 0
0 1 00000006 00000000 0000007f 0
0 1 00000004 00000000 ffff80ff 0
0 2 0000000c 00000000 a5c3e10f 0
1 0 00000001 000000ab 00000000 0
1 1 0000000a 0000beef 00000000 0
2 0 00000008 00000000 00000000 1
2 0 00000001 00000000 000000ab 0
0 2 00000008 00000000 8000beef 0
1 2 0000000c deadbeef 00000000 0
0 0 0000000f 00000000 ffffffef 0
2 0 00000006 00000000 00000000 1
0 1 00000006 00000000 ffff807f 0
